// ==== verilog/ahb_pkg.sv ====
package ahb_pkg;

  typedef logic [31:0] haddr_t;   // Byte address
  typedef logic [31:0] hdata_t;   // One bus word
  typedef logic [1:0]  htrans_t;

  // Only single transfers, so SEQ and BUSY never show up
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // Address phase as a master drives it
  // Write data is carried here and not one cycle later
  typedef struct packed {
    htrans_t trans;
    haddr_t  addr;
    logic    write;   // 1 for a write
    hdata_t  wdata;
  } ahb_req_t;

  // Data phase return
  typedef struct packed {
    hdata_t rdata;
    logic   ready;
    logic   resp;
  } ahb_rsp_t;

endpackage

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

  // Cores sharing the instruction bus
  localparam int NUM_MASTERS = 5;

  typedef logic [2:0]             master_idx_t;   // Index of one master
  typedef logic [NUM_MASTERS-1:0] master_vec_t;   // One bit per master

  // Instruction memory, word organised
  localparam int MEM_WORDS = 256;

  typedef logic [7:0] mem_idx_t;   // Word index, address bits 9:2

  // Memory sits at address 0
  // First byte address past the end, anything at or above is an error
  localparam logic [31:0] MEM_LIMIT = 32'h0000_0400;

endpackage

// ==== verilog/ahb_input_stage.sv ====
module ahb_input_stage import ahb_pkg::*; (
  input  logic     hclk,
  input  logic     i_rst_n,
  input  ahb_req_t i_req,        // Live address phase from the master
  input  logic     i_ready_in,   // Bus ready routed back by the matrix
  input  logic     i_grant,      // Matrix took our address phase
  output ahb_req_t o_req,        // Request as seen by the matrix
  output logic     o_valid,
  output logic     o_ready       // Ready seen by the master
);

  ahb_req_t held_req;   // Copy of a transfer that lost arbitration
  logic     pending;    // Held copy waits for a grant
  logic     issue;      // Master starts a transfer this cycle

  // A NONSEQ only counts while the master sees ready high
  assign issue = o_ready && (i_req.trans == HTRANS_NONSEQ);

  // Master is stalled from the cycle after capture until its data phase
  assign o_ready = i_ready_in && !pending;

  // Held copy wins over the live bus while pending
  assign o_valid = pending || issue;
  assign o_req   = pending ? held_req : i_req;

  always_ff @(posedge hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pending <= 1'b0;
    end else if (pending) begin
      if (i_grant) begin
        pending <= 1'b0;      // Address phase gone, data phase next cycle
      end
    end else if (issue && !i_grant) begin
      pending <= 1'b1;        // Lost arbitration in the issue cycle
    end
  end

  // Payload only, taken in the issue cycle of a transfer that must wait
  always_ff @(posedge hclk) begin
    if (issue && !i_grant) begin
      held_req <= i_req;
    end
  end

endmodule

// ==== verilog/ahb_bus_matrix.sv ====
module ahb_bus_matrix import ahb_pkg::*, soc_pkg::*; (
  input  logic        hclk,
  input  logic        i_rst_n,
  input  ahb_req_t    i_req [NUM_MASTERS],   // Requests from the input stages
  input  master_vec_t i_valid,
  output master_vec_t o_grant,
  output ahb_req_t    o_mem_req,             // Granted address phase
  input  ahb_rsp_t    i_mem_rsp,
  output ahb_rsp_t    o_rsp [NUM_MASTERS]
);

  master_idx_t rr_ptr;      // Highest priority master this cycle
  master_idx_t win_idx;     // Winner of this cycle
  logic        win_vld;
  master_idx_t owner_idx;   // Master whose data phase is on the bus
  logic        owner_vld;

  // Round robin search
  // Starts at rr_ptr and wraps, so every requester is reached within
  // NUM_MASTERS grants
  always_comb begin
    int unsigned idx;
    win_vld = 1'b0;
    win_idx = '0;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      idx = 32'(rr_ptr) + 32'(k);
      if (idx >= NUM_MASTERS) begin
        idx = idx - NUM_MASTERS;
      end
      // Address phase is only accepted while the bus is ready
      if (!win_vld && i_valid[idx] && i_mem_rsp.ready) begin
        win_vld = 1'b1;
        win_idx = master_idx_t'(idx);
      end
    end
  end

  // At most one grant per cycle
  always_comb begin
    o_grant = '0;
    if (win_vld) begin
      o_grant[win_idx] = 1'b1;
    end
  end

  // Address mux towards the memory
  // With no winner only trans matters, forced to IDLE
  always_comb begin
    o_mem_req = i_req[win_idx];
    if (!win_vld) begin
      o_mem_req.trans = HTRANS_IDLE;
    end
  end

  // Pointer moves past the last winner, owner follows the address phase
  always_ff @(posedge hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rr_ptr    <= '0;
      owner_idx <= '0;
      owner_vld <= 1'b0;
    end else if (i_mem_rsp.ready) begin
      owner_vld <= win_vld;
      if (win_vld) begin
        owner_idx <= win_idx;
        if (win_idx == master_idx_t'(NUM_MASTERS - 1)) begin
          rr_ptr <= '0;
        end else begin
          rr_ptr <= win_idx + 3'd1;
        end
      end
    end
  end

  // Response routing
  // Ready is the shared bus ready, data and resp only reach the owner
  for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_rsp
    logic owner_hit;

    assign owner_hit = owner_vld && (owner_idx == master_idx_t'(m));

    assign o_rsp[m].ready = i_mem_rsp.ready;
    assign o_rsp[m].rdata = owner_hit ? i_mem_rsp.rdata : '0;
    assign o_rsp[m].resp  = owner_hit ? i_mem_rsp.resp : HRESP_OKAY;
  end

endmodule

// ==== verilog/iahb_mem_ctrl.sv ====
module iahb_mem_ctrl import ahb_pkg::*, soc_pkg::*; (
  input  logic     hclk,
  input  logic     i_rst_n,
  input  ahb_req_t i_req,   // Address phase from the matrix
  output ahb_rsp_t o_rsp    // Data phase, one cycle later
);

  localparam int IDX_MSB = $bits(mem_idx_t) + 1;   // Top word index bit of the address

  hdata_t   mem [MEM_WORDS];
  logic     dp_vld;     // Data phase of a real transfer
  logic     dp_write;
  logic     dp_err;     // Address at or past MEM_LIMIT
  mem_idx_t dp_idx;
  hdata_t   dp_wdata;

  // Address phase register, control part
  always_ff @(posedge hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dp_vld   <= 1'b0;
      dp_write <= 1'b0;
      dp_err   <= 1'b0;
    end else begin
      dp_vld   <= (i_req.trans == HTRANS_NONSEQ);
      dp_write <= i_req.write;
      dp_err   <= (i_req.addr >= MEM_LIMIT);
    end
  end

  // Address phase register, payload part
  always_ff @(posedge hclk) begin
    dp_idx   <= i_req.addr[IDX_MSB:2];
    dp_wdata <= i_req.wdata;
  end

  // Write lands at the end of the data phase
  // Out of range writes are dropped
  always_ff @(posedge hclk) begin
    if (dp_vld && dp_write && !dp_err) begin
      mem[dp_idx] <= dp_wdata;
    end
  end

  assign o_rsp.ready = 1'b1;   // Zero wait states
  assign o_rsp.resp  = (dp_vld && dp_err) ? HRESP_ERROR : HRESP_OKAY;
  assign o_rsp.rdata = (dp_vld && !dp_write && !dp_err) ? mem[dp_idx] : '0;

endmodule

// ==== verilog/iahb_soc_top.sv ====
module iahb_soc_top import ahb_pkg::*, soc_pkg::*; (
  input  logic     hclk,
  input  logic     i_rst_n,
  input  ahb_req_t i_req [NUM_MASTERS],   // One port per core
  output ahb_rsp_t o_rsp [NUM_MASTERS]
);

  ahb_req_t    stage_req [NUM_MASTERS];   // Stage to matrix
  ahb_rsp_t    mtx_rsp   [NUM_MASTERS];   // Matrix back to masters
  master_vec_t stage_vld;
  master_vec_t stage_gnt;
  master_vec_t stage_rdy;                 // Ready as the cores see it
  ahb_req_t    mem_req;
  ahb_rsp_t    mem_rsp;

  for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
    ahb_input_stage u_stage (
      .hclk       (hclk),
      .i_rst_n    (i_rst_n),
      .i_req      (i_req[m]),
      .i_ready_in (mtx_rsp[m].ready),
      .i_grant    (stage_gnt[m]),
      .o_req      (stage_req[m]),
      .o_valid    (stage_vld[m]),
      .o_ready    (stage_rdy[m])
    );

    // Stage owns ready, matrix owns data and response
    assign o_rsp[m].ready = stage_rdy[m];
    assign o_rsp[m].rdata = mtx_rsp[m].rdata;
    assign o_rsp[m].resp  = mtx_rsp[m].resp;
  end

  ahb_bus_matrix u_matrix (
    .hclk      (hclk),
    .i_rst_n   (i_rst_n),
    .i_req     (stage_req),
    .i_valid   (stage_vld),
    .o_grant   (stage_gnt),
    .o_mem_req (mem_req),
    .i_mem_rsp (mem_rsp),
    .o_rsp     (mtx_rsp)
  );

  iahb_mem_ctrl u_imem (
    .hclk    (hclk),
    .i_rst_n (i_rst_n),
    .i_req   (mem_req),
    .o_rsp   (mem_rsp)
  );

endmodule

// ==== bench/iahb_sva.sv ====
module iahb_sva import soc_pkg::*; (
  input logic        hclk,
  input logic        i_rst_n,
  input master_vec_t i_valid,   // Request flags into the matrix
  input master_vec_t i_grant    // Grant vector out of the matrix
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;   // Failed assertions so far
  master_vec_t late;           // Request left waiting too long

  // Consecutive cycles a master has requested without a grant
  for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_wait
    int unsigned wait_cnt;

    always_ff @(posedge hclk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        wait_cnt <= 0;
      end else if (i_valid[m] && !i_grant[m]) begin
        wait_cnt <= wait_cnt + 1;
      end else begin
        wait_cnt <= 0;
      end
    end

    assign late[m] = i_valid[m] && (wait_cnt >= NUM_MASTERS);
  end

  a_onehot_grant: assert property (@(posedge hclk) disable iff (!i_rst_n) $onehot0(i_grant))
    else begin
      fail_cnt++;
      $error("Matrix granted more than one master: %b", i_grant);
    end

  a_grant_to_requester: assert property (
    @(posedge hclk) disable iff (!i_rst_n) (i_grant & ~i_valid) == '0)
    else begin
      fail_cnt++;
      $error("Grant %b went to a master without a request %b", i_grant, i_valid);
    end

  // Round robin bound
  a_no_starvation: assert property (@(posedge hclk) disable iff (!i_rst_n) late == '0)
    else begin
      fail_cnt++;
      $error("Request not granted within %0d cycles, masters %b", NUM_MASTERS, late);
    end

endmodule

// ==== bench/tb_iahb_soc_top.sv ====
module tb_iahb_soc_top import ahb_pkg::*, soc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_XFERS  = 40;                // Per master, parallel phase
  localparam int CROSS_READS = 12;
  localparam int WAIT_LIMIT  = NUM_MASTERS + 2;   // Cycles before a stall is reported

  logic     hclk;
  logic     rst_n;
  ahb_req_t req [NUM_MASTERS];
  ahb_rsp_t rsp [NUM_MASTERS];

  hdata_t      model_mem [MEM_WORDS];   // Expected memory contents
  logic        model_wr  [MEM_WORDS];   // Word written at least once
  logic [31:0] rng [NUM_MASTERS];       // One LCG stream per master
  int          checks;
  int          mismatches;
  int          timeouts;

  iahb_soc_top dut (
    .hclk    (hclk),
    .i_rst_n (rst_n),
    .i_req   (req),
    .o_rsp   (rsp)
  );

  bind ahb_bus_matrix iahb_sva u_sva (
    .hclk    (hclk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_grant (o_grant)
  );

  initial begin
    hclk = 1'b0;
    forever #4 hclk = ~hclk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] draw(input int m);
    rng[m] = lcg_next(rng[m]);
    return rng[m];
  endfunction

  // Master index in bits 9:7, word in bits 6:2
  function automatic haddr_t slice_addr(input int m, input int word);
    haddr_t a;
    a = '0;
    a[9:7] = m[2:0];
    a[6:2] = word[4:0];
    return a;
  endfunction

  task automatic next_cycle();
    @(posedge hclk);
    #1;   // Registered outputs settled, inputs change here
  endtask

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("Mismatch at %0d ns: %s", $time, msg);
  endtask

  // Issue one transfer and wait for its data phase
  // Returns 1 ns into the data phase cycle with the master idle again
  task automatic do_transfer(input int m, input logic wr, input haddr_t addr,
                             input hdata_t wdata, output hdata_t rdata,
                             output logic resp, output logic done);
    int lat;
    lat   = 0;
    done  = 1'b0;
    rdata = '0;
    resp  = HRESP_OKAY;
    while (!rsp[m].ready && lat < WAIT_LIMIT) begin   // Issue needs ready high
      next_cycle();
      lat++;
    end
    if (!rsp[m].ready) begin
      timeouts++;
      $display("Timeout at %0d ns: master %0d never got ready to issue", $time, m);
    end else begin
      req[m] = '{trans: HTRANS_NONSEQ, addr: addr, write: wr, wdata: wdata};
      lat = 0;
      while (!done && lat < WAIT_LIMIT) begin
        next_cycle();
        lat++;
        if (rsp[m].ready) begin   // First ready after issue is the data phase
          done  = 1'b1;
          rdata = rsp[m].rdata;
          resp  = rsp[m].resp;
        end
      end
      req[m].trans = HTRANS_IDLE;
      if (!done) begin
        timeouts++;
        $display("Timeout at %0d ns: master %0d stalled with ready low for %0d cycles",
                 $time, m, lat);
      end else begin
        checks++;
        if (lat > NUM_MASTERS) begin
          report_mismatch($sformatf("master %0d data phase after %0d cycles, limit %0d",
                                    m, lat, NUM_MASTERS));
        end
      end
    end
  endtask

  // One transfer checked against the memory model
  task automatic run_transfer(input int m, input logic wr, input haddr_t addr,
                              input hdata_t wdata);
    hdata_t   rdata;
    logic     resp;
    logic     done;
    mem_idx_t idx;
    idx = addr[9:2];
    do_transfer(m, wr, addr, wdata, rdata, resp, done);
    if (done) begin
      checks++;
      if (addr >= MEM_LIMIT) begin
        if (resp !== HRESP_ERROR || rdata !== '0) begin
          report_mismatch($sformatf("master %0d addr %h out of range, resp %b rdata %h",
                                    m, addr, resp, rdata));
        end
      end else if (resp !== HRESP_OKAY) begin
        report_mismatch($sformatf("master %0d addr %h resp %b, expected OKAY", m, addr, resp));
      end else if (wr) begin
        model_mem[idx] = wdata;   // Word changes at the write's data phase
        model_wr[idx]  = 1'b1;
      end else if (model_wr[idx] && rdata !== model_mem[idx]) begin
        report_mismatch($sformatf("master %0d read addr %h got %h expected %h",
                                  m, addr, rdata, model_mem[idx]));
      end
    end
  endtask

  task automatic check_idle(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      next_cycle();
      for (int m = 0; m < NUM_MASTERS; m++) begin
        checks++;
        if (rsp[m].ready !== 1'b1 || rsp[m].resp !== HRESP_OKAY) begin
          report_mismatch($sformatf("idle master %0d sees ready %b resp %b",
                                    m, rsp[m].ready, rsp[m].resp));
        end
      end
    end
  endtask

  // Back to back reads and writes in the master's own slice
  task automatic random_traffic(input int m, input int count);
    logic [31:0] r;
    for (int n = 0; n < count; n++) begin
      r = draw(m);
      run_transfer(m, r[31], slice_addr(m, int'(r[20:16])), draw(m));
    end
  endtask

  task automatic cross_reads(input int m, input int count);
    logic [31:0] r;
    int          owner;
    for (int n = 0; n < count; n++) begin
      r     = draw(m);
      owner = (m + 1 + int'(r[31:30])) % NUM_MASTERS;   // Never the master itself
      run_transfer(m, 1'b0, slice_addr(owner, int'(r[20:16])), '0);
    end
  endtask

  task automatic range_test(input int m);
    haddr_t base;
    hdata_t keep;
    base = slice_addr(m, 7);
    keep = draw(m);
    run_transfer(m, 1'b1, base, keep);
    run_transfer(m, 1'b1, base | MEM_LIMIT, ~keep);   // Same low index, must not land
    run_transfer(m, 1'b0, base | 32'h8000_0000, '0);
    run_transfer(m, 1'b0, base, '0);                   // Still holds keep
  endtask

  initial begin
    logic [31:0] seed;
    int          sva_fails;
    rst_n      = 1'b0;
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    seed       = 32'd98;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      req[m] = '{trans: HTRANS_IDLE, addr: '0, write: 1'b0, wdata: '0};
      seed   = lcg_next(seed);
      rng[m] = seed;
    end
    for (int w = 0; w < MEM_WORDS; w++) begin
      model_wr[w] = 1'b0;
    end
    repeat (10) @(posedge hclk);
    #1;
    rst_n = 1'b1;

    check_idle(4);
    run_transfer(0, 1'b1, slice_addr(0, 3), draw(0));   // Single master write, read back
    run_transfer(0, 1'b0, slice_addr(0, 3), '0);

    fork   // All masters busy every cycle
      random_traffic(0, RAND_XFERS);
      random_traffic(1, RAND_XFERS);
      random_traffic(2, RAND_XFERS);
      random_traffic(3, RAND_XFERS);
      random_traffic(4, RAND_XFERS);
    join
    check_idle(2);
    range_test(2);

    fork
      cross_reads(0, CROSS_READS);
      cross_reads(1, CROSS_READS);
      cross_reads(2, CROSS_READS);
      cross_reads(3, CROSS_READS);
      cross_reads(4, CROSS_READS);
    join
    check_idle(2);

    sva_fails = dut.u_matrix.u_sva.fail_cnt;
    $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             checks, mismatches, timeouts, sva_fails);
    if (mismatches == 0 && timeouts == 0 && sva_fails == 0 && checks > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/ahb_pkg.sv
verilog/soc_pkg.sv
verilog/ahb_input_stage.sv
verilog/ahb_bus_matrix.sv
verilog/iahb_mem_ctrl.sv
verilog/iahb_soc_top.sv
bench/iahb_sva.sv
bench/tb_iahb_soc_top.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run, the simulation log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_iahb_soc_top -o tb_sim -f flist.f > build.log 2>&1 &&
  ./obj_dir/tb_sim > sim.log 2>&1
grep -q "^TESTBENCH PASSED$" sim.log 2>/dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }
